//--- flist.f
source/ptw_pkg.sv
source/pte_checker.sv
source/wb_pte_fetch.sv
source/ptw_walk_ctrl.sv
source/ptw_top.sv
tests/ptw_checker.sv
tests/tb_ptw.sv

//--- Bender.yml
package:
  name: ptw_sv39

sources:
  - source/ptw_pkg.sv
  - source/pte_checker.sv
  - source/wb_pte_fetch.sv
  - source/ptw_walk_ctrl.sv
  - source/ptw_top.sv
  - target: test
    files:
      - tests/ptw_checker.sv
      - tests/tb_ptw.sv

//--- tests/tb_ptw.sv
// Testbench for the Sv39 walker: directed walks, faults and random page tables.
// Memory is a sparse map of 64-bit PTEs; missing entries read as zero.
// Ack delay is random from 0 to 5 cycles per beat.
`default_nettype none

module tb_ptw;
    import ptw_pkg::*;

    localparam int          NUM_RANDOM = 40;
    // directed walks plus the disabled translation test
    localparam int          NUM_DIRECTED = 15;
    localparam int          NUM_TESTS = NUM_DIRECTED + NUM_RANDOM;
    localparam longint      TIMEOUT = (NUM_TESTS * 3 * 8 + 1000) * 100;
    localparam [PPN_W-1:0]  ROOT = 44'h80;

    logic        clk_i;
    logic        rst_ni;
    tlb_req_t    itlb_req, dtlb_req;
    logic [PPN_W-1:0]  satp_ppn;
    logic [ASID_W-1:0] asid;
    logic        en_tr, en_ldst, mxr, is_store;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    tlb_update_t itlb_upd, dtlb_upd;
    logic [VADDR_W-1:0] upd_vaddr;
    logic        active, walk_instr, ptw_err;

    // expected result of the running walk
    logic        exp_err, exp_instr;
    tlb_update_t exp_upd;
    logic [VADDR_W-1:0] exp_vaddr;
    logic [2:0][PLEN-1:0] exp_adr;
    int          exp_nadr;
    int          test_id = 0;
    int          done_cnt, chk_fails;
    int          tb_fails = 0;
    int          tb_tests = 0;

    logic [PTE_W-1:0] mem [logic [PLEN-1:0]];

    ptw_top UUT (
        .clk_i(clk_i), .rst_ni(rst_ni), .itlb_req_i(itlb_req), .dtlb_req_i(dtlb_req),
        .satp_ppn_i(satp_ppn), .asid_i(asid), .enable_translation_i(en_tr),
        .en_ld_st_translation_i(en_ldst), .mxr_i(mxr), .lsu_is_store_i(is_store),
        .wb_req_o(wb_req), .wb_rsp_i(wb_rsp), .itlb_update_o(itlb_upd),
        .dtlb_update_o(dtlb_upd), .update_vaddr_o(upd_vaddr), .ptw_active_o(active),
        .walking_instr_o(walk_instr), .ptw_error_o(ptw_err)
    );

    ptw_checker u_check (
        .clk_i(clk_i), .rst_ni(rst_ni), .wb_req_i(wb_req), .itlb_update_i(itlb_upd),
        .dtlb_update_i(dtlb_upd), .update_vaddr_i(upd_vaddr), .ptw_active_i(active),
        .walking_instr_i(walk_instr), .ptw_error_i(ptw_err), .exp_err_i(exp_err),
        .exp_instr_i(exp_instr), .exp_update_i(exp_upd), .exp_vaddr_i(exp_vaddr),
        .exp_adr_i(exp_adr), .exp_nadr_i(exp_nadr),
        .test_id_i(test_id), .done_cnt_o(done_cnt), .fail_cnt_o(chk_fails)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // flags are d a g u x w r v from bit 7 down
    function automatic pte_t make_pte(input logic [PPN_W-1:0] ppn, input logic [7:0] flags);
        pte_t p;
        p     = '0;
        p.ppn = ppn;
        {p.d, p.a, p.g, p.u, p.x, p.w, p.r, p.v} = flags;
        return p;
    endfunction

    task automatic set_pte(input logic [PPN_W-1:0] tbl, input int idx, input pte_t p);
        mem[{tbl, idx[8:0], 3'b000}] = p;
    endtask

    // Sv39 walk over mem, independent of the DUT
    function automatic void expected_walk(input logic [VADDR_W-1:0] va, input logic instr,
            input logic store, input logic mx, input logic [ASID_W-1:0] as,
            output tlb_update_t upd, output logic err,
            output logic [2:0][PLEN-1:0] adrs, output int n);
        pte_t             p;
        logic [PPN_W-1:0] ppn;
        logic             glob;
        logic             done;
        logic             bad;
        ppn  = ROOT;
        glob = 1'b0;
        done = 1'b0;
        err  = 1'b0;
        upd  = '0;
        adrs = '0;
        n    = 0;
        for (int lvl = 0; lvl < 3 && !done; lvl++) begin
            adrs[lvl] = {ppn, va[38-9*lvl -: 9], 3'b000};
            n = lvl + 1;
            p = mem.exists(adrs[lvl]) ? mem[adrs[lvl]] : '0;
            done = 1'b1;
            if (!p.v || (p.w && !p.r)) begin
                err = 1'b1;
            end else if (!p.r && !p.x) begin
                if (lvl == 2) begin
                    err = 1'b1;
                end else begin
                    glob = glob | p.g;
                    ppn  = p.ppn;
                    done = 1'b0;
                end
            end else begin
                bad = ~p.a;
                if (lvl == 0 && p.ppn[17:0] != 0) bad = 1'b1;
                if (lvl == 1 && p.ppn[8:0] != 0) bad = 1'b1;
                if (instr && !p.x) bad = 1'b1;
                if (!instr && !(p.r || (mx && p.x))) bad = 1'b1;
                if (!instr && store && !(p.w && p.d)) bad = 1'b1;
                err = bad;
                if (!bad) begin
                    upd.valid     = 1'b1;
                    upd.is_1g     = (lvl == 0);
                    upd.is_2m     = (lvl == 1);
                    upd.vpn       = va[38:12];
                    upd.asid      = as;
                    upd.content   = p;
                    upd.content.g = p.g | glob;
                end
            end
        end
    endfunction

    // --------------------
    // stimulus tasks
    // --------------------
    // both raises the itlb miss too, dtlb must win
    task automatic run_walk(input logic instr, input logic both, input logic [VADDR_W-1:0] va,
                            input logic store, input logic mx);
        @(posedge clk_i);
        #1;
        asid     = ASID_W'($urandom);
        is_store = store;
        mxr      = mx;
        expected_walk(va, instr, store, mx, asid, exp_upd, exp_err, exp_adr, exp_nadr);
        exp_instr = instr;
        exp_vaddr = va;
        test_id++;
        if (instr || both) itlb_req = {1'b1, 1'b0, instr ? va : ~va};
        if (!instr) dtlb_req = {1'b1, 1'b0, va};
        @(posedge clk_i);
        #1;
        itlb_req.access = 1'b0;
        dtlb_req.access = 1'b0;
        wait (done_cnt == test_id);
    endtask

    // a miss with its translation enable off must not touch the bus
    task automatic check_no_walk;
        int bad;
        bad = 0;
        @(posedge clk_i);
        #1;
        en_tr    = 1'b0;
        itlb_req = {1'b1, 1'b0, 39'h12345000};
        repeat (10) begin
            @(posedge clk_i);
            if (wb_req.cyc || active) bad++;
        end
        #1;
        itlb_req.access = 1'b0;
        en_tr = 1'b1;
        // same for a dtlb miss with load/store translation off
        en_ldst  = 1'b0;
        dtlb_req = {1'b1, 1'b0, 39'h12345000};
        repeat (10) begin
            @(posedge clk_i);
            if (wb_req.cyc || active) bad++;
        end
        #1;
        dtlb_req.access = 1'b0;
        en_ldst = 1'b1;
        tb_tests++;
        if (bad != 0) begin
            tb_fails++;
            $display("disabled translation: a walk started with the enable low");
        end
        $display("disabled translation test: %s", (bad == 0) ? "pass" : "fail");
    endtask

    // wishbone slave with random ack delay
    initial begin
        int   delay;
        logic busy;
        busy   = 1'b0;
        delay  = 0;
        wb_rsp = '0;
        forever begin
            @(posedge clk_i);
            #1;
            wb_rsp.ack = 1'b0;
            if (wb_req.cyc) begin
                if (!busy) begin
                    busy  = 1'b1;
                    delay = $urandom % 6;
                end
                if (delay == 0) begin
                    wb_rsp.ack = 1'b1;
                    wb_rsp.dat = mem.exists(wb_req.adr) ? mem[wb_req.adr] : '0;
                    busy = 1'b0;
                end else begin
                    delay--;
                end
            end
        end
    end

    initial begin
        #(TIMEOUT);
        $display("timeout: the walks did not finish in time");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        logic [PPN_W-1:0] tbl;
        logic [PPN_W-1:0] rppn;
        logic [VADDR_W-1:0] va;
        logic [7:0] fl;
        void'($urandom(32'h2312));
        rst_ni = 1'b0;
        itlb_req = '0;
        dtlb_req = '0;
        satp_ppn = ROOT;
        asid = '0;
        en_tr = 1'b1;
        en_ldst = 1'b1;
        mxr = 1'b0;
        is_store = 1'b0;
        exp_err = 1'b0;
        exp_instr = 1'b0;
        exp_upd = '0;
        exp_vaddr = '0;
        exp_adr = '0;
        exp_nadr = 0;
        repeat (10) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        // three-level 4K path and superpages
        set_pte(ROOT, 1, make_pte(44'h81, 8'h01));
        set_pte(44'h81, 2, make_pte(44'h82, 8'h01));
        set_pte(44'h82, 3, make_pte(44'h1234, 8'hC7));
        set_pte(ROOT, 4, make_pte(44'h40000, 8'h49));
        set_pte(ROOT, 5, make_pte(44'h83, 8'h21));
        set_pte(44'h83, 7, make_pte(44'h200, 8'h4B));
        // fault pages, root index 10 left empty
        set_pte(ROOT, 11, make_pte(44'h40000, 8'h45));
        set_pte(ROOT, 12, make_pte(44'h40000, 8'h43));
        set_pte(ROOT, 13, make_pte(44'h40000, 8'h03));
        set_pte(ROOT, 14, make_pte(44'h40000, 8'h47));
        set_pte(ROOT, 15, make_pte(44'h40000, 8'hC3));
        set_pte(ROOT, 16, make_pte(44'h40001, 8'h43));
        set_pte(ROOT, 17, make_pte(44'h84, 8'h01));
        set_pte(44'h84, 0, make_pte(44'h85, 8'h01));
        set_pte(44'h85, 0, make_pte(44'h86, 8'h01));
        set_pte(ROOT, 18, make_pte(44'h40000, 8'h49));
        run_walk(1'b0, 1'b0, {9'd1, 9'd2, 9'd3, 12'h0}, 1'b0, 1'b0);
        run_walk(1'b1, 1'b0, {9'd4, 9'd9, 9'd9, 12'h0}, 1'b0, 1'b0);
        run_walk(1'b1, 1'b0, {9'd5, 9'd7, 9'd1, 12'h0}, 1'b0, 1'b0);
        run_walk(1'b0, 1'b0, {9'd10, 18'd0, 12'h0}, 1'b0, 1'b0);
        run_walk(1'b0, 1'b0, {9'd11, 18'd0, 12'h0}, 1'b0, 1'b0);
        run_walk(1'b1, 1'b0, {9'd12, 18'd0, 12'h0}, 1'b0, 1'b0);
        run_walk(1'b0, 1'b0, {9'd13, 18'd0, 12'h0}, 1'b0, 1'b0);
        run_walk(1'b0, 1'b0, {9'd14, 18'd0, 12'h0}, 1'b1, 1'b0);
        run_walk(1'b0, 1'b0, {9'd15, 18'd0, 12'h0}, 1'b1, 1'b0);
        run_walk(1'b0, 1'b0, {9'd16, 18'd0, 12'h0}, 1'b0, 1'b0);
        run_walk(1'b0, 1'b0, {9'd17, 18'd0, 12'h0}, 1'b0, 1'b0);
        run_walk(1'b0, 1'b0, {9'd18, 18'd0, 12'h0}, 1'b0, 1'b1);
        run_walk(1'b0, 1'b0, {9'd18, 18'd0, 12'h0}, 1'b0, 1'b0);
        run_walk(1'b0, 1'b1, {9'd1, 9'd2, 9'd3, 12'h0}, 1'b0, 1'b0);
        check_no_walk();
        // --------------------
        // random tables along each random path
        // --------------------
        repeat (NUM_RANDOM) begin
            va  = VADDR_W'({$urandom, $urandom});
            tbl = ROOT;
            for (int lvl = 0; lvl < 3; lvl++) begin
                fl   = 8'($urandom);
                fl[0] = ($urandom % 8) != 0;
                rppn = PPN_W'({$urandom, $urandom});
                if ($urandom % 3 == 0) begin
                    fl[3:1] = 3'b000;
                    rppn = 44'h1000 + lvl * 44'h1000 + ($urandom % 4096);
                end else if ($urandom % 2) begin
                    rppn[17:0] = '0;
                end
                set_pte(tbl, va[38-9*lvl -: 9], make_pte(rppn, fl));
                tbl = rppn;
            end
            run_walk(1'($urandom % 2), 1'b0, va, 1'($urandom % 2), 1'($urandom % 2));
        end
        repeat (2) @(posedge clk_i);
        $display("tests run: %0d, failed: %0d", test_id + tb_tests, chk_fails + tb_fails);
        if (chk_fails == 0 && tb_fails == 0 && done_cnt == test_id) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/ptw_checker.sv
// Watches the walker ports and compares each walk end with the expected result.
// The expected values must be stable from the request until the walk ends.
// A walk end is an update valid or an error pulse; the result line follows a cycle later.
`default_nettype none

module ptw_checker (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  ptw_pkg::wb_req_t                  wb_req_i,
    input  ptw_pkg::tlb_update_t              itlb_update_i,
    input  ptw_pkg::tlb_update_t              dtlb_update_i,
    input  logic [ptw_pkg::VADDR_W-1:0]       update_vaddr_i,
    input  logic                              ptw_active_i,
    input  logic                              walking_instr_i,
    input  logic                              ptw_error_i,
    input  logic                              exp_err_i,
    input  logic                              exp_instr_i,
    input  ptw_pkg::tlb_update_t              exp_update_i,
    input  logic [ptw_pkg::VADDR_W-1:0]       exp_vaddr_i,
    input  logic [2:0][ptw_pkg::PLEN-1:0]     exp_adr_i,
    input  int                                exp_nadr_i,
    input  int                                test_id_i,
    output int                                done_cnt_o,
    output int                                fail_cnt_o
);
    import ptw_pkg::*;

    int          adr_idx = 0;
    int          errs = 0;
    logic        cyc_q = 1'b0;
    logic        end_q = 1'b0;
    tlb_update_t act_upd;
    tlb_update_t other_upd;

    initial begin
        done_cnt_o = 0;
        fail_cnt_o = 0;
    end

    task automatic mismatch(input string name, input logic [127:0] exp, input logic [127:0] act);
        $display("ERR t=%0t %s exp=%h act=%h", $time, name, exp, act);
        errs++;
    endtask

    // --------------------
    // sample on the rising edge, inputs move later
    // --------------------
    always @(posedge clk_i) begin
        if (rst_ni) begin
            // walk ended last cycle, walker must be idle now
            if (end_q) begin
                if (ptw_active_i) begin
                    mismatch("ptw_active_o", 128'd0, 128'd1);
                end
                if (errs != 0) begin
                    fail_cnt_o++;
                end
                $display("test %0d: %s", test_id_i, (errs == 0) ? "pass" : "fail");
                done_cnt_o++;
                errs    = 0;
                adr_idx = 0;
                end_q   = 1'b0;
            end
            // classic single reads raise stb together with cyc
            if (wb_req_i.stb != wb_req_i.cyc) begin
                mismatch("wb_req_o.stb", wb_req_i.cyc, wb_req_i.stb);
            end
            // one pte address per bus cycle
            if (wb_req_i.cyc && !cyc_q) begin
                if (adr_idx >= exp_nadr_i) begin
                    $display("test %0d: PTE fetch beyond the expected walk depth", test_id_i);
                    errs++;
                end else if (wb_req_i.adr != exp_adr_i[adr_idx]) begin
                    mismatch("wb_req_o.adr", exp_adr_i[adr_idx], wb_req_i.adr);
                end
                adr_idx++;
            end
            cyc_q = wb_req_i.cyc;
            if (itlb_update_i.valid || dtlb_update_i.valid || ptw_error_i) begin
                if (walking_instr_i != exp_instr_i) begin
                    mismatch("walking_instr_o", exp_instr_i, walking_instr_i);
                end
                // active still high in the end cycle
                if (!ptw_active_i) begin
                    mismatch("ptw_active_o", 128'd1, 128'd0);
                end
                if (update_vaddr_i != exp_vaddr_i) begin
                    mismatch("update_vaddr_o", exp_vaddr_i, update_vaddr_i);
                end
                // walk must stop at the level where the reference stopped
                if (adr_idx != exp_nadr_i) begin
                    $display("test %0d: walk ended after %0d PTE fetches instead of %0d",
                             test_id_i, adr_idx, exp_nadr_i);
                    errs++;
                end
                act_upd   = exp_instr_i ? itlb_update_i : dtlb_update_i;
                other_upd = exp_instr_i ? dtlb_update_i : itlb_update_i;
                if (exp_err_i) begin
                    if (!ptw_error_i) begin
                        mismatch("ptw_error_o", 128'd1, 128'd0);
                    end
                    if (itlb_update_i.valid || dtlb_update_i.valid) begin
                        $display("test %0d: TLB update seen where a page fault was due",
                                 test_id_i);
                        errs++;
                    end
                end else begin
                    if (ptw_error_i) begin
                        mismatch("ptw_error_o", 128'd0, 128'd1);
                    end
                    if (other_upd.valid) begin
                        mismatch("other tlb valid", 128'd0, 128'd1);
                    end
                    if (act_upd != exp_update_i) begin
                        mismatch(exp_instr_i ? "itlb_update_o" : "dtlb_update_o",
                                 exp_update_i, act_upd);
                    end
                end
                end_q = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/ptw_top.sv
// Sv39 page table walker with a Wishbone classic read port for PTEs.
// No PMP check, no flush and no hardware A/D update.
// Refills are single-cycle pulses without a handshake.
`default_nettype none

module ptw_top (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  ptw_pkg::tlb_req_t             itlb_req_i,
    input  ptw_pkg::tlb_req_t             dtlb_req_i,
    input  logic [ptw_pkg::PPN_W-1:0]     satp_ppn_i,
    input  logic [ptw_pkg::ASID_W-1:0]    asid_i,
    input  logic                          enable_translation_i,
    input  logic                          en_ld_st_translation_i,
    input  logic                          mxr_i,
    input  logic                          lsu_is_store_i,
    output ptw_pkg::wb_req_t              wb_req_o,
    input  ptw_pkg::wb_rsp_t              wb_rsp_i,
    output ptw_pkg::tlb_update_t          itlb_update_o,
    output ptw_pkg::tlb_update_t          dtlb_update_o,
    output logic [ptw_pkg::VADDR_W-1:0]   update_vaddr_o,
    output logic                          ptw_active_o,
    output logic                          walking_instr_o,
    output logic                          ptw_error_o
);
    import ptw_pkg::*;

    logic          fetch_req;
    logic [PLEN-1:0] fetch_adr;
    logic          pte_valid;
    pte_t          pte;
    pte_verdict_e  verdict;
    ptw_lvl_e      lvl;
    logic          is_instr;

    // walk control and refill
    ptw_walk_ctrl u_walk_ctrl (
        .clk_i                  (clk_i),
        .rst_ni                 (rst_ni),
        .itlb_req_i             (itlb_req_i),
        .dtlb_req_i             (dtlb_req_i),
        .satp_ppn_i             (satp_ppn_i),
        .asid_i                 (asid_i),
        .enable_translation_i   (enable_translation_i),
        .en_ld_st_translation_i (en_ld_st_translation_i),
        .pte_valid_i            (pte_valid),
        .pte_i                  (pte),
        .verdict_i              (verdict),
        .fetch_req_o            (fetch_req),
        .fetch_adr_o            (fetch_adr),
        .lvl_o                  (lvl),
        .is_instr_o             (is_instr),
        .itlb_update_o          (itlb_update_o),
        .dtlb_update_o          (dtlb_update_o),
        .update_vaddr_o         (update_vaddr_o),
        .ptw_active_o           (ptw_active_o),
        .walking_instr_o        (walking_instr_o),
        .ptw_error_o            (ptw_error_o)
    );

    // pte read over wishbone
    wb_pte_fetch u_fetch (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .fetch_req_i (fetch_req),
        .fetch_adr_i (fetch_adr),
        .wb_req_o    (wb_req_o),
        .wb_rsp_i    (wb_rsp_i),
        .pte_valid_o (pte_valid),
        .pte_o       (pte)
    );

    // classification of the held pte
    pte_checker u_checker (
        .pte_i          (pte),
        .lvl_i          (lvl),
        .is_instr_i     (is_instr),
        .mxr_i          (mxr_i),
        .lsu_is_store_i (lsu_is_store_i),
        .verdict_o      (verdict)
    );

endmodule

`default_nettype wire

//--- source/ptw_walk_ctrl.sv
// Sv39 walk FSM: miss arbitration, level tracking, next pointer and TLB refill.
// A DTLB miss wins over a simultaneous ITLB miss.
// Vaddr and ASID are sampled when the walk starts; the TLB may drop them after.
// One walk at a time and no flush; a started walk always runs to its end.
`default_nettype none

module ptw_walk_ctrl (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  ptw_pkg::tlb_req_t             itlb_req_i,
    input  ptw_pkg::tlb_req_t             dtlb_req_i,
    input  logic [ptw_pkg::PPN_W-1:0]     satp_ppn_i,
    input  logic [ptw_pkg::ASID_W-1:0]    asid_i,
    input  logic                          enable_translation_i,
    input  logic                          en_ld_st_translation_i,
    input  logic                          pte_valid_i,
    input  ptw_pkg::pte_t                 pte_i,
    input  ptw_pkg::pte_verdict_e         verdict_i,
    output logic                          fetch_req_o,
    output logic [ptw_pkg::PLEN-1:0]      fetch_adr_o,
    output ptw_pkg::ptw_lvl_e             lvl_o,
    output logic                          is_instr_o,
    output ptw_pkg::tlb_update_t          itlb_update_o,
    output ptw_pkg::tlb_update_t          dtlb_update_o,
    output logic [ptw_pkg::VADDR_W-1:0]   update_vaddr_o,
    output logic                          ptw_active_o,
    output logic                          walking_instr_o,
    output logic                          ptw_error_o
);
    import ptw_pkg::*;

    walk_state_e        state_q, state_d;
    ptw_lvl_e           lvl_q, lvl_d;
    logic               is_instr_q, is_instr_d;
    // global bit seen on any pointer level
    logic               global_q, global_d;
    logic [VADDR_W-1:0] vaddr_q, vaddr_d;
    logic [ASID_W-1:0]  asid_q, asid_d;
    logic               dtlb_miss;
    logic               itlb_miss;
    logic [VADDR_W-1:0] start_vaddr;
    logic [VPN_W-1:0]   next_vpn;
    logic               leaf_hit;
    tlb_update_t        update;

    // --------------------
    // miss arbitration
    // --------------------
    assign dtlb_miss = dtlb_req_i.access & ~dtlb_req_i.hit & en_ld_st_translation_i;
    // itlb only when the dtlb is not accessing at all
    assign itlb_miss = itlb_req_i.access & ~itlb_req_i.hit & ~dtlb_req_i.access
                     & enable_translation_i;
    assign start_vaddr = dtlb_miss ? dtlb_req_i.vaddr : itlb_req_i.vaddr;

    // vpn[1] after the 1G level, vpn[0] after the 2M level
    assign next_vpn = (lvl_q == LVL1) ? vaddr_q[29:21] : vaddr_q[20:12];

    assign leaf_hit = (state_q == WAIT_PTE) & pte_valid_i & (verdict_i == PTE_LEAF);

    // status outputs
    assign ptw_active_o    = (state_q != IDLE);
    assign ptw_error_o     = (state_q == PROPAGATE_ERROR);
    assign walking_instr_o = is_instr_q;
    assign is_instr_o      = is_instr_q;
    assign lvl_o           = lvl_q;
    assign update_vaddr_o  = vaddr_q;

    // --------------------
    // tlb refill
    // --------------------
    always_comb begin
        update           = '0;
        update.is_1g     = (lvl_q == LVL1);
        update.is_2m     = (lvl_q == LVL2);
        update.vpn       = vaddr_q[VADDR_W-1:12];
        update.asid      = asid_q;
        update.content   = pte_i;
        // a global pointer makes the whole subtree global
        update.content.g = pte_i.g | global_q;
        itlb_update_o       = update;
        itlb_update_o.valid = leaf_hit & is_instr_q;
        dtlb_update_o       = update;
        dtlb_update_o.valid = leaf_hit & ~is_instr_q;
    end

    // --------------------
    // walk fsm
    // --------------------
    always_comb begin
        state_d     = state_q;
        lvl_d       = lvl_q;
        is_instr_d  = is_instr_q;
        global_d    = global_q;
        vaddr_d     = vaddr_q;
        asid_d      = asid_q;
        fetch_req_o = 1'b0;
        fetch_adr_o = '0;
        case (state_q)
            IDLE: begin
                lvl_d      = LVL1;
                global_d   = 1'b0;
                is_instr_d = itlb_miss;
                // root table entry from satp and vpn[2]
                fetch_adr_o = {satp_ppn_i, start_vaddr[VADDR_W-1:VADDR_W-VPN_W], 3'b000};
                if (dtlb_miss || itlb_miss) begin
                    vaddr_d     = start_vaddr;
                    asid_d      = asid_i;
                    fetch_req_o = 1'b1;
                    state_d     = WAIT_PTE;
                end
            end
            WAIT_PTE: begin
                fetch_adr_o = {pte_i.ppn, next_vpn, 3'b000};
                if (pte_valid_i) begin
                    case (verdict_i)
                        // refill goes out this cycle
                        PTE_LEAF: state_d = IDLE;
                        PTE_NEXT: begin
                            global_d    = global_q | pte_i.g;
                            lvl_d       = (lvl_q == LVL1) ? LVL2 : LVL3;
                            fetch_req_o = 1'b1;
                        end
                        default: state_d = PROPAGATE_ERROR;
                    endcase
                end
            end
            // one-cycle error pulse then back to idle
            PROPAGATE_ERROR: state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= IDLE;
            lvl_q      <= LVL1;
            is_instr_q <= 1'b0;
            global_q   <= 1'b0;
        end else begin
            state_q    <= state_d;
            lvl_q      <= lvl_d;
            is_instr_q <= is_instr_d;
            global_q   <= global_d;
        end
    end

    // walk payload, only read while a walk is active
    always_ff @(posedge clk_i) begin
        vaddr_q <= vaddr_d;
        asid_q  <= asid_d;
    end

endmodule

`default_nettype wire

//--- source/wb_pte_fetch.sv
// Wishbone classic read master fetching one 64-bit PTE per start.
// A start is accepted only while no cycle is open; the controller guarantees it.
// Ack with cyc low is ignored. No error or retry handling.
`default_nettype none

module wb_pte_fetch (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      fetch_req_i,
    input  logic [ptw_pkg::PLEN-1:0]  fetch_adr_i,
    output ptw_pkg::wb_req_t          wb_req_o,
    input  ptw_pkg::wb_rsp_t          wb_rsp_i,
    output logic                      pte_valid_o,
    output ptw_pkg::pte_t             pte_o
);
    import ptw_pkg::*;

    logic            cyc_q;
    logic            pte_valid_q;
    logic            beat_done;
    logic [PLEN-1:0] adr_q;
    pte_t            pte_q;

    // ack sampled inside an open cycle
    assign beat_done = cyc_q & wb_rsp_i.ack;

    // cyc and stb move together in classic single reads
    assign wb_req_o.cyc = cyc_q;
    assign wb_req_o.stb = cyc_q;
    assign wb_req_o.adr = adr_q;

    assign pte_valid_o = pte_valid_q;
    assign pte_o       = pte_q;

    // bus strobes and the result pulse
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cyc_q       <= 1'b0;
            pte_valid_q <= 1'b0;
        end else begin
            if (fetch_req_i) begin
                cyc_q <= 1'b1;
            end else if (beat_done) begin
                cyc_q <= 1'b0;
            end
            pte_valid_q <= beat_done;
        end
    end

    // address held for the whole cycle, data held until the next beat
    always_ff @(posedge clk_i) begin
        if (fetch_req_i) begin
            adr_q <= fetch_adr_i;
        end
        if (beat_done) begin
            pte_q <= pte_t'(wb_rsp_i.dat);
        end
    end

endmodule

`default_nettype wire

//--- source/pte_checker.sv
// Purely combinational PTE classifier for one Sv39 walk step.
// A and D bits are managed by software, so a clear bit is a page fault.
// The verdict is meaningful only while the fetched PTE is current.
`default_nettype none

module pte_checker (
    input  ptw_pkg::pte_t         pte_i,
    input  ptw_pkg::ptw_lvl_e     lvl_i,
    input  logic                  is_instr_i,
    input  logic                  mxr_i,
    input  logic                  lsu_is_store_i,
    output ptw_pkg::pte_verdict_e verdict_o
);
    import ptw_pkg::*;

    logic is_leaf;
    logic bad_encoding;
    logic misaligned;
    logic perm_fault;

    // r or x marks a leaf, neither marks a pointer
    assign is_leaf = pte_i.r | pte_i.x;

    // invalid entry or the reserved write-only encoding
    assign bad_encoding = ~pte_i.v | (pte_i.w & ~pte_i.r);

    // --------------------
    // superpage alignment
    // --------------------
    // low ppn bits of a superpage leaf must be zero
    always_comb begin
        misaligned = 1'b0;
        if (lvl_i == LVL1) begin
            misaligned = (pte_i.ppn[17:0] != '0);
        end else if (lvl_i == LVL2) begin
            misaligned = (pte_i.ppn[8:0] != '0);
        end
    end

    // --------------------
    // permissions
    // --------------------
    always_comb begin
        perm_fault = 1'b0;
        if (is_instr_i) begin
            // fetch needs an executable page that was accessed
            perm_fault = ~pte_i.x | ~pte_i.a;
        end else begin
            // loads need r, or x when mxr makes executable pages readable
            perm_fault = ~pte_i.a | ~(pte_i.r | (pte_i.x & mxr_i));
            // stores also need a writable page already marked dirty
            if (lsu_is_store_i && (!pte_i.w || !pte_i.d)) begin
                perm_fault = 1'b1;
            end
        end
    end

    // final verdict
    always_comb begin
        if (bad_encoding) begin
            verdict_o = PTE_FAULT;
        end else if (!is_leaf) begin
            // no level below LVL3 to point to
            verdict_o = (lvl_i == LVL3) ? PTE_FAULT : PTE_NEXT;
        end else if (misaligned || perm_fault) begin
            verdict_o = PTE_FAULT;
        end else begin
            verdict_o = PTE_LEAF;
        end
    end

endmodule

`default_nettype wire

//--- source/ptw_pkg.sv
// Shared widths, PTE layout, TLB and Wishbone types for the Sv39 walker.
// Sv39 only: 39-bit virtual and 56-bit physical addresses with 4K pages.
// The Wishbone types cover read-only classic cycles of one 64-bit beat.
`default_nettype none

package ptw_pkg;

    // --------------------
    // widths
    // --------------------
    localparam int unsigned VADDR_W = 39;
    localparam int unsigned PLEN    = 56;
    localparam int unsigned PPN_W   = 44;
    localparam int unsigned ASID_W  = 16;
    // one vpn slice per table level
    localparam int unsigned VPN_W   = 9;
    // a PTE and one bus beat share this width
    localparam int unsigned PTE_W   = 64;

    // --------------------
    // page table entry
    // --------------------
    typedef struct packed {
        logic [9:0]       reserved;
        logic [PPN_W-1:0] ppn;
        logic [1:0]       rsw;
        logic             d;
        logic             a;
        logic             g;
        logic             u;
        logic             x;
        logic             w;
        logic             r;
        logic             v;
    } pte_t;

    // miss request from one TLB
    typedef struct packed {
        logic               access;
        logic               hit;
        logic [VADDR_W-1:0] vaddr;
    } tlb_req_t;

    // refill toward a TLB, valid for a single cycle
    typedef struct packed {
        logic              valid;
        logic              is_2m;
        logic              is_1g;
        logic [26:0]       vpn;
        logic [ASID_W-1:0] asid;
        pte_t              content;
    } tlb_update_t;

    // --------------------
    // wishbone classic
    // --------------------
    // adr is a byte address on an 8-byte boundary
    typedef struct packed {
        logic            cyc;
        logic            stb;
        logic [PLEN-1:0] adr;
    } wb_req_t;

    typedef struct packed {
        logic             ack;
        logic [PTE_W-1:0] dat;
    } wb_rsp_t;

    // LVL1 is the 1G level, LVL3 the 4K level
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } ptw_lvl_e;

    // outcome of checking one fetched PTE
    typedef enum logic [1:0] {
        PTE_LEAF,
        PTE_NEXT,
        PTE_FAULT
    } pte_verdict_e;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_PTE,
        PROPAGATE_ERROR
    } walk_state_e;

endpackage

`default_nettype wire
